// ==== flist.f ====
source/eeprom_pkg.sv
source/scl_timer.sv
source/bit_engine.sv
source/eeprom_ctrl.sv
source/eeprom_master.sv
test/eeprom_model.sv
test/eeprom_assertions.sv
test/tb_eeprom_master.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_eeprom_master -f flist.f -o sim

./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST PASSED" sim.log; then
    exit 0
else
    exit 1
fi

// ==== source/bit_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module bit_engine
(
    input  wire                 CLK,
    input  wire                 RESET,
    input  wire                 go,
    input  eeprom_pkg::bus_op_t op,
    input  wire [7:0]           tx_byte,
    input  wire                 tx_last,
    input  wire                 low_mid,
    input  wire                 high_mid,
    input  wire                 sda_in,
    output logic                sda_low,
    output logic                run,
    output logic                op_done,
    output logic                ack_ok,
    output logic [7:0]          rx_byte
);

    eeprom_pkg::bus_op_t op_r;
    logic                last_r;
    logic [7:0]          shreg;
    logic [3:0]          bit_cnt;   // low phases seen in this op
    logic [3:0]          end_cnt;
    logic                active;

    // start and stop take one serial clock, bytes take nine
    assign end_cnt = (op_r == eeprom_pkg::op_start || op_r == eeprom_pkg::op_stop) ?
                     4'd1 : 4'd9;

    assign run     = active;
    assign rx_byte = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            sda_low <= 1'b0;
            op_done <= 1'b0;
            ack_ok  <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            op_done <= 1'b0;
            if (go)
            begin
                active  <= 1'b1;
                bit_cnt <= '0;
            end
            else if (active && low_mid)
            begin
                bit_cnt <= bit_cnt + 4'd1;
                case (op_r)
                    eeprom_pkg::op_start: sda_low <= 1'b0;   // line high before start
                    eeprom_pkg::op_stop:  sda_low <= 1'b1;
                    eeprom_pkg::op_send:  sda_low <= (bit_cnt < 4'd8) ? ~shreg[7] : 1'b0;
                    eeprom_pkg::op_recv:  sda_low <= (bit_cnt < 4'd8) ? 1'b0 : ~last_r;
                    default:              sda_low <= 1'b0;
                endcase
            end
            else if (active && high_mid && bit_cnt != 4'd0)
            begin
                // data falls / rises while scl high
                if (op_r == eeprom_pkg::op_start)
                    sda_low <= 1'b1;
                else if (op_r == eeprom_pkg::op_stop)
                    sda_low <= 1'b0;

                if (bit_cnt == end_cnt)
                begin
                    active  <= 1'b0;
                    op_done <= 1'b1;
                    if (op_r == eeprom_pkg::op_send)
                        ack_ok <= ~sda_in;   // slave pulls low to ack
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (go)
        begin
            op_r   <= op;
            last_r <= tx_last;
            shreg  <= tx_byte;
        end
        else if (active && low_mid && op_r == eeprom_pkg::op_send && bit_cnt < 4'd8)
            shreg <= {shreg[6:0], 1'b0};
        else if (active && high_mid && op_r == eeprom_pkg::op_recv &&
                 bit_cnt != 4'd0 && bit_cnt < 4'd9)
            shreg <= {shreg[6:0], sda_in};   // msb first
    end

endmodule

`default_nettype wire

// ==== source/eeprom_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module eeprom_ctrl
(
    input  wire [0:0]                      CLK,
    input  wire                            RESET,
    input  wire                            wr,
    input  wire                            rd,
    input  wire [eeprom_pkg::ADDR_W-1:0]   addr,
    input  wire [7:0]                      wdata,
    input  wire                            op_done,
    input  wire                            ack_ok,
    input  wire [7:0]                      rx_byte,
    output logic                           go,
    output eeprom_pkg::bus_op_t            op,
    output logic [7:0]                     tx_byte,
    output logic                           tx_last,
    output logic [7:0]                     rdata,
    output logic                           done,
    output logic                           nack_err,
    output logic                           busy
);

    eeprom_pkg::ctrl_state_t       state;
    eeprom_pkg::ctrl_state_t       next_state;
    logic [eeprom_pkg::ADDR_W-1:0] addr_r;
    logic [7:0]                    wdata_r;
    logic                          is_rd;
    logic                          issued;   // waiting on op_done
    logic [7:0]                    ctrl_byte;

    // write direction, read sets bit 0
    assign ctrl_byte = {eeprom_pkg::DEVICE_CODE, addr_r[eeprom_pkg::ADDR_W-1:8], 1'b0};
    assign tx_last   = (state == eeprom_pkg::rdata);

    always_comb
    begin
        op      = eeprom_pkg::op_stop;
        tx_byte = 8'h00;
        case (state)
            eeprom_pkg::start,
            eeprom_pkg::restart: op = eeprom_pkg::op_start;
            eeprom_pkg::ctrl_wr: begin op = eeprom_pkg::op_send; tx_byte = ctrl_byte; end
            eeprom_pkg::addr:    begin op = eeprom_pkg::op_send; tx_byte = addr_r[7:0]; end
            eeprom_pkg::wdata:   begin op = eeprom_pkg::op_send; tx_byte = wdata_r; end
            eeprom_pkg::ctrl_rd: begin op = eeprom_pkg::op_send; tx_byte = ctrl_byte | 8'h01; end
            eeprom_pkg::rdata:   op = eeprom_pkg::op_recv;
            default:             op = eeprom_pkg::op_stop;
        endcase
    end

    // missing ack goes straight to stop
    always_comb
    begin
        case (state)
            eeprom_pkg::start:   next_state = eeprom_pkg::ctrl_wr;
            eeprom_pkg::ctrl_wr: next_state = ack_ok ? eeprom_pkg::addr : eeprom_pkg::stop;
            eeprom_pkg::addr:
                if (!ack_ok)
                    next_state = eeprom_pkg::stop;
                else
                    next_state = is_rd ? eeprom_pkg::restart : eeprom_pkg::wdata;
            eeprom_pkg::restart: next_state = eeprom_pkg::ctrl_rd;
            eeprom_pkg::ctrl_rd: next_state = ack_ok ? eeprom_pkg::rdata : eeprom_pkg::stop;
            eeprom_pkg::wdata,
            eeprom_pkg::rdata:   next_state = eeprom_pkg::stop;
            eeprom_pkg::stop:    next_state = eeprom_pkg::finish;
            default:             next_state = state;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= eeprom_pkg::idle;
            issued   <= 1'b0;
            go       <= 1'b0;
            done     <= 1'b0;
            busy     <= 1'b0;
            nack_err <= 1'b0;
        end
        else
        begin
            go   <= 1'b0;
            done <= 1'b0;
            case (state)
                eeprom_pkg::idle:
                    if (wr || rd)
                    begin
                        busy     <= 1'b1;
                        nack_err <= 1'b0;
                        state    <= eeprom_pkg::start;
                    end
                eeprom_pkg::finish:
                begin
                    done  <= 1'b1;   // same edge as busy falling
                    busy  <= 1'b0;
                    state <= eeprom_pkg::idle;
                end
                default:
                    if (!issued)
                    begin
                        go     <= 1'b1;
                        issued <= 1'b1;
                    end
                    else if (op_done)
                    begin
                        issued <= 1'b0;
                        state  <= next_state;
                        if (op == eeprom_pkg::op_send && !ack_ok)
                            nack_err <= 1'b1;
                    end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == eeprom_pkg::idle && (wr || rd))
        begin
            addr_r  <= addr;
            wdata_r <= wdata;
            is_rd   <= ~wr;   // write wins if both
        end
        if (state == eeprom_pkg::rdata && op_done)
            rdata <= rx_byte;
    end

endmodule

`default_nettype wire

// ==== source/eeprom_master.sv ====
`timescale 1ns/1ns
`default_nettype none

module eeprom_master
(
    input  wire                          CLK,
    input  wire                          RESET,
    input  wire                          wr,
    input  wire                          rd,
    input  wire [eeprom_pkg::ADDR_W-1:0] addr,
    input  wire [7:0]                    wdata,
    input  wire                          sda_in,
    output logic                         scl,
    output logic                         sda_low,
    output logic [7:0]                   rdata,
    output logic                         done,
    output logic                         nack_err,
    output logic                         busy
);

    logic                run;
    logic                low_mid;
    logic                high_mid;
    logic                go;
    eeprom_pkg::bus_op_t op;
    logic [7:0]          tx_byte;
    logic                tx_last;
    logic                op_done;
    logic                ack_ok;
    logic [7:0]          rx_byte;

    scl_timer u_timer
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .run      (run),
        .scl      (scl),
        .low_mid  (low_mid),
        .high_mid (high_mid)
    );

    bit_engine u_engine
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .go       (go),
        .op       (op),
        .tx_byte  (tx_byte),
        .tx_last  (tx_last),
        .low_mid  (low_mid),
        .high_mid (high_mid),
        .sda_in   (sda_in),
        .sda_low  (sda_low),
        .run      (run),
        .op_done  (op_done),
        .ack_ok   (ack_ok),
        .rx_byte  (rx_byte)
    );

    eeprom_ctrl u_ctrl
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .op_done  (op_done),
        .ack_ok   (ack_ok),
        .rx_byte  (rx_byte),
        .go       (go),
        .op       (op),
        .tx_byte  (tx_byte),
        .tx_last  (tx_last),
        .rdata    (rdata),
        .done     (done),
        .nack_err (nack_err),
        .busy     (busy)
    );

endmodule

`default_nettype wire

// ==== source/eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;

    // CLK cycles per quarter of the serial clock
    localparam int SCL_QUARTER = 1;

    // upper nibble of the control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    localparam int ADDR_W = 11;

    typedef enum logic [3:0]
    {
        idle,
        start,
        ctrl_wr,
        addr,
        wdata,
        restart,   // repeated start before the read control byte
        ctrl_rd,
        rdata,
        stop,
        finish
    } ctrl_state_t;

    typedef enum logic [1:0]
    {
        op_start,
        op_stop,
        op_send,
        op_recv
    } bus_op_t;

endpackage

`default_nettype wire

// ==== source/scl_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module scl_timer
(
    input  wire  CLK,
    input  wire  RESET,
    input  wire  run,
    output logic scl,
    output logic low_mid,
    output logic high_mid
);

    logic [7:0] qcnt;
    logic [1:0] phase;   // 0,1 high   2,3 low
    logic       q_end;

    assign q_end = (qcnt == 8'(eeprom_pkg::SCL_QUARTER - 1));

    // held in phase 0 while stopped, so each run starts high
    always_ff @(posedge CLK)
    begin
        if (RESET || !run)
        begin
            qcnt  <= '0;
            phase <= '0;
        end
        else if (q_end)
        begin
            qcnt  <= '0;
            phase <= phase + 2'd1;
        end
        else
            qcnt <= qcnt + 8'd1;
    end

    assign scl      = ~(run & phase[1]);
    assign high_mid = run & q_end & (phase == 2'd0);
    assign low_mid  = run & q_end & (phase == 2'd2);

endmodule

`default_nettype wire

// ==== test/eeprom_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module eeprom_assertions
(
    input wire                 CLK,
    input wire                 RESET,
    input wire                 scl,
    input wire                 sda_low,
    input wire                 done,
    input wire                 busy,
    input wire                 nack_err,
    input eeprom_pkg::bus_op_t op_r
);

    // line may only move under a high scl for start and stop
    data_stable: assert property (@(posedge CLK) disable iff (RESET)
        ($changed(sda_low) && scl && $past(scl)) |->
        (op_r == eeprom_pkg::op_start || op_r == eeprom_pkg::op_stop))
        else $error("data line changed while scl high");

    done_single: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done)
        else $error("done longer than one cycle");

    done_busy_fall: assert property (@(posedge CLK) disable iff (RESET)
        $fell(busy) |-> done)
        else $error("busy fell without done");

    done_not_busy: assert property (@(posedge CLK) disable iff (RESET)
        done |-> (!busy && $past(busy)))
        else $error("done without busy falling");

    bus_idle: assert property (@(posedge CLK) disable iff (RESET)
        !busy |-> (scl && !sda_low))
        else $error("bus not idle while not busy");

    reset_state: assert property (@(posedge CLK)
        RESET |=> (scl && !sda_low && !done && !busy && !nack_err))
        else $error("outputs not in reset state");

endmodule

bind eeprom_master eeprom_assertions u_chk
(
    .CLK      (CLK),
    .RESET    (RESET),
    .scl      (scl),
    .sda_low  (sda_low),
    .done     (done),
    .busy     (busy),
    .nack_err (nack_err),
    .op_r     (u_engine.op_r)
);

`default_nettype wire

// ==== test/eeprom_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module eeprom_model
(
    input  wire  scl,
    input  wire  sda,
    input  wire  nack_force,
    output logic pull_low
);

    logic [7:0]                    mem [0:(1 << eeprom_pkg::ADDR_W) - 1];
    logic [7:0]                    sh;
    logic [eeprom_pkg::ADDR_W-1:0] ptr;
    int                            bitn = 0;      // scl rises seen in this byte
    int                            byte_no = 0;
    int                            stop_count = 0;
    logic                          active = 1'b0;
    logic                          tx_mode = 1'b0;
    logic                          going_tx = 1'b0;
    logic                          ok;

    initial
    begin
        pull_low = 1'b0;
        ptr = '0;
        for (int i = 0; i < (1 << eeprom_pkg::ADDR_W); i++)
            mem[i] = 8'hFF;   // erased
    end

    // start, also a repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            active   = 1'b1;
            bitn     = 0;
            byte_no  = 0;
            tx_mode  = 1'b0;
            going_tx = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1 && active)
        begin
            active = 1'b0;
            stop_count++;
        end
    end

    always @(posedge scl)
    begin
        if (active && bitn < 9)
        begin
            if (bitn < 8 && !tx_mode)
                sh = {sh[6:0], sda};
            bitn++;
        end
    end

    always @(negedge scl)
    begin
        if (active)
        begin
            if (bitn == 8 && !tx_mode)
            begin
                ok = !nack_force;
                case (byte_no)
                    0:
                    begin
                        ok = ok && (sh[7:4] == eeprom_pkg::DEVICE_CODE);
                        if (ok && sh[0])
                            going_tx = 1'b1;
                        else if (ok)
                            ptr[eeprom_pkg::ADDR_W-1:8] = sh[3:1];   // block select
                    end
                    1:       if (ok) ptr[7:0] = sh;
                    default: if (ok) mem[ptr] = sh;
                endcase
                byte_no++;
                pull_low = ok;   // ack by pulling low
            end
            else if (bitn == 8)
                pull_low = 1'b0;   // master acks our byte
            else if (bitn == 9)
            begin
                bitn     = 0;
                pull_low = 1'b0;
                if (going_tx)
                begin
                    going_tx = 1'b0;
                    tx_mode  = 1'b1;
                    sh       = mem[ptr];
                    pull_low = ~sh[7];
                end
            end
            else if (tx_mode && bitn >= 1)
                pull_low = ~sh[7 - bitn];
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_eeprom_master.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_eeprom_master;

    localparam int LIMIT = 2000;   // CLK cycles per wait

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wdata;
    logic        nack_force;
    logic [15:0] lfsr;
    logic [7:0]  got;
    logic [6:0]  low7;
    logic [7:0]  blk_data [8];
    wire         sda_bus;
    wire         scl;
    wire         sda_low;
    wire         model_pull;
    wire  [7:0]  rdata;
    wire         done;
    wire         nack_err;
    wire         busy;
    int          errors = 0;
    int          test_errs = 0;
    int          tests = 0;
    int          failed = 0;
    int          stops;
    bit          hung = 1'b0;

    assign sda_bus = ~(sda_low | model_pull);   // wired-AND

    eeprom_master UUT
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .sda_in   (sda_bus),
        .scl      (scl),
        .sda_low  (sda_low),
        .rdata    (rdata),
        .done     (done),
        .nack_err (nack_err),
        .busy     (busy)
    );

    eeprom_model u_model
    (
        .scl        (scl),
        .sda        (sda_bus),
        .nack_force (nack_force),
        .pull_low   (model_pull)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // galois lfsr, one step per bit
    function automatic logic [15:0] rand_bits(int nbits);
        logic [15:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            val  = {val[14:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic wait_done();
        int cnt;
        cnt = 0;
        @(negedge CLK);
        while (!done && cnt < LIMIT)
        begin
            cnt++;
            @(negedge CLK);
        end
        if (!done)
        begin
            $display("timeout: done never came at %0t", $time);
            hung = 1'b1;
        end
    endtask

    task automatic strobe(bit is_wr, logic [10:0] a_in, logic [7:0] d_in);
        @(negedge CLK);
        wr    = is_wr;
        rd    = !is_wr;
        addr  = a_in;
        wdata = d_in;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic do_write(logic [10:0] a_in, logic [7:0] d_in);
        strobe(1'b1, a_in, d_in);
        wait_done();
    endtask

    task automatic do_read(logic [10:0] a_in, output logic [7:0] d_out);
        strobe(1'b0, a_in, 8'h00);
        wait_done();
        d_out = rdata;
    endtask

    task automatic check_byte(string what, logic [7:0] g, logic [7:0] e);
        assert (g === e)
        else
        begin
            $display("ERROR at %0t: %s got %02h expected %02h", $time, what, g, e);
            test_errs++;
        end
    endtask

    task automatic check_bit(string what, logic g, logic e);
        assert (g === e)
        else
        begin
            $display("ERROR at %0t: %s got %b expected %b", $time, what, g, e);
            test_errs++;
        end
    endtask

    task automatic end_test(string name);
        tests++;
        if (test_errs != 0)
            failed++;
        $display("test %s: %s", name, (test_errs == 0) ? "ok" : "failed");
        errors    += test_errs;
        test_errs = 0;
    endtask

    initial
    begin
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wdata      = '0;
        nack_force = 1'b0;
        lfsr       = 16'd5839;
        repeat (3) @(negedge CLK);
        RESET = 1'b0;

        do_write(11'h0A5, 8'h3C);
        do_read(11'h0A5, got);
        check_byte("write then read", got, 8'h3C);
        check_bit("nack_err", nack_err, 1'b0);
        end_test("write_read");

        // same low byte in every block so a lost block select aliases
        low7 = 7'(rand_bits(7));   // bit 7 clear, fixed addresses set it
        for (int i = 0; i < 8 && !hung; i++)
        begin
            blk_data[i] = 8'(rand_bits(8));
            do_write({3'(i), 1'b0, low7}, blk_data[i]);
        end
        for (int i = 0; i < 8 && !hung; i++)
        begin
            do_read({3'(i), 1'b0, low7}, got);
            check_byte("block readback", got, blk_data[i]);
        end
        end_test("upper_bits");

        if (!hung)
        begin
            do_read(11'h3C5, got);
            check_byte("erased read", got, 8'hFF);
            end_test("erased");
        end

        if (!hung)
        begin
            nack_force = 1'b1;
            do_write(11'h1A3, 8'h5A);
            check_bit("nack_err on nack", nack_err, 1'b1);
            check_bit("stopped after control byte", u_model.byte_no == 1, 1'b1);
            nack_force = 1'b0;
            do_read(11'h1A3, got);
            check_byte("after nack", got, 8'hFF);
            check_bit("nack_err cleared", nack_err, 1'b0);
            end_test("nack");
        end

        if (!hung)
        begin
            stops = u_model.stop_count;
            strobe(1'b1, 11'h2B4, 8'hC3);
            strobe(1'b1, 11'h7E9, 8'h96);   // lands while busy
            wait_done();
            check_bit("one transfer", (u_model.stop_count - stops) == 1, 1'b1);
            do_read(11'h2B4, got);
            check_byte("first write", got, 8'hC3);
            do_read(11'h7E9, got);
            check_byte("ignored write", got, 8'hFF);
            end_test("busy_strobe");
        end

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0 && !hung)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
